//--- all.f
hw/rvIsaPkg.sv
hw/corePkg.sv
hw/instrDecode.sv
hw/aluExecute.sv
hw/resultSelect.sv
hw/rvExecCore.sv
verif/rvExecCore_assertions.sv
verif/coreChecker.sv
verif/tbTop.sv

//--- hw/aluExecute.sv
`default_nettype none

module aluExecute
    import corePkg::*;
    import rvIsaPkg::*;
(
    input  decStageT decStage,
    output xlenT     aluResult,
    output logic     branchTaken,
    output xlenT     target
);

    xlenT       op1;
    xlenT       op2;
    xlenT       targetSum;
    logic [4:0] shamt;
    logic       eq;
    logic       ltS;
    logic       ltU;
    logic       condMet;

    assign op1   = decStage.ctrl.op1Pc ? decStage.pc : decStage.rs1Val;
    assign op2   = decStage.ctrl.op2Imm ? decStage.imm : decStage.rs2Val;
    assign shamt = op2[4:0];   // also covers shamt field of slli/srli/srai

    always_comb
    begin
        case (decStage.ctrl.aluOp)
            AluAdd:
                aluResult = op1 + op2;
            AluSub:
                aluResult = op1 - op2;
            AluXor:
                aluResult = op1 ^ op2;
            AluOr:
                aluResult = op1 | op2;
            AluAnd:
                aluResult = op1 & op2;
            AluSll:
                aluResult = op1 << shamt;
            AluSrl:
                aluResult = op1 >> shamt;
            AluSra:
                aluResult = xlenT'($signed(op1) >>> shamt);
            AluSlt:
                aluResult = {{(Xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
            AluSltu:
                aluResult = {{(Xlen-1){1'b0}}, op1 < op2};   // sltiu imm already sign extended
            default:
                aluResult = '0;
        endcase
    end

    // branch comparator works on the raw register values
    assign eq  = decStage.rs1Val == decStage.rs2Val;
    assign ltS = $signed(decStage.rs1Val) < $signed(decStage.rs2Val);
    assign ltU = decStage.rs1Val < decStage.rs2Val;

    always_comb
    begin
        case (decStage.ctrl.brCond)
            F3Beq:
                condMet = eq;
            F3Bne:
                condMet = !eq;
            F3Blt:
                condMet = ltS;
            F3Bge:
                condMet = !ltS;
            F3Bltu:
                condMet = ltU;
            F3Bgeu:
                condMet = !ltU;
            default:
                condMet = 1'b0;
        endcase
    end

    assign branchTaken = decStage.ctrl.isBranch && condMet;

    // jal and branches start from pc, jalr from rs1
    assign targetSum = op1 + decStage.imm;
    assign target    = {targetSum[Xlen-1:1], targetSum[0] & decStage.ctrl.op1Pc};

endmodule

`default_nettype wire

//--- hw/corePkg.sv
`default_nettype none

package corePkg;

    localparam int Xlen = 32;

    typedef logic [Xlen-1:0] xlenT;
    typedef logic [4:0]      regAddrT;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluXor,
        AluOr,
        AluAnd,
        AluSll,
        AluSrl,
        AluSra,
        AluSlt,
        AluSltu
    } aluOpT;

    // source of the rd write
    typedef enum logic [1:0] {
        WbAlu,
        WbImm,
        WbLink
    } wbSelT;

    typedef struct packed {
        aluOpT      aluOp;
        logic       op1Pc;    // operand 1 is pc, else rs1
        logic       op2Imm;   // operand 2 is imm, else rs2
        wbSelT      wbSel;
        logic       rdWe;
        logic       isBranch;
        logic       isJump;
        logic [2:0] brCond;
        logic       illegal;
    } ctrlT;

    typedef struct packed {
        logic    valid;
        ctrlT    ctrl;
        xlenT    pc;
        xlenT    rs1Val;
        xlenT    rs2Val;
        xlenT    imm;
        regAddrT rdAddr;
    } decStageT;

    typedef struct packed {
        logic    rdWe;
        regAddrT rdAddr;
        xlenT    rdData;
        xlenT    nextPc;
        logic    illegal;
    } resultT;

endpackage

`default_nettype wire

//--- hw/instrDecode.sv
`default_nettype none

module instrDecode
    import corePkg::*;
    import rvIsaPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      inValid,
    input  instrWordT instr,
    input  xlenT      pc,
    input  xlenT      rs1Val,
    input  xlenT      rs2Val,
    output decStageT  decStage
);

    ctrlT ctrl;
    xlenT imm;
    logic immOp;
    logic shiftOp;
    logic altOk;
    logic f7Base;
    logic f7Alt;

    assign immOp   = instr.r.opcode == OpImm;
    assign shiftOp = instr.r.funct3 == F3Sll || instr.r.funct3 == F3SrlSra;
    assign f7Base  = instr.r.funct7 == 7'b0;
    assign f7Alt   = instr.r.funct7 == Funct7Alt;
    // alt code only valid for sub, sra and srai
    assign altOk   = instr.r.funct3 == F3SrlSra || (instr.r.funct3 == F3AddSub && !immOp);

    always_comb
    begin
        ctrl        = '0;
        ctrl.aluOp  = AluAdd;
        ctrl.wbSel  = WbAlu;
        ctrl.brCond = instr.b.funct3;
        case (instr.r.opcode)
            OpReg, OpImm:
            begin
                ctrl.op2Imm = immOp;
                ctrl.rdWe   = 1'b1;
                case (instr.r.funct3)
                    F3AddSub:
                        ctrl.aluOp = (!immOp && f7Alt) ? AluSub : AluAdd;
                    F3Sll:
                        ctrl.aluOp = AluSll;
                    F3Slt:
                        ctrl.aluOp = AluSlt;
                    F3Sltu:
                        ctrl.aluOp = AluSltu;
                    F3Xor:
                        ctrl.aluOp = AluXor;
                    F3SrlSra:
                        ctrl.aluOp = f7Alt ? AluSra : AluSrl;
                    F3Or:
                        ctrl.aluOp = AluOr;
                    F3And:
                        ctrl.aluOp = AluAnd;
                endcase
                // funct7 is only decoded for R type and immediate shifts
                if ((!immOp || shiftOp) && !f7Base && !(altOk && f7Alt))
                    ctrl.illegal = 1'b1;
            end
            OpLui:
            begin
                ctrl.rdWe  = 1'b1;
                ctrl.wbSel = WbImm;
            end
            OpAuipc:
            begin
                ctrl.rdWe   = 1'b1;
                ctrl.op1Pc  = 1'b1;
                ctrl.op2Imm = 1'b1;
            end
            OpBranch:
            begin
                ctrl.op1Pc  = 1'b1;
                ctrl.op2Imm = 1'b1;
                case (instr.b.funct3)
                    F3Beq, F3Bne, F3Blt, F3Bge, F3Bltu, F3Bgeu:
                        ctrl.isBranch = 1'b1;
                    default:
                        ctrl.illegal = 1'b1;
                endcase
            end
            OpJal:
            begin
                ctrl.rdWe   = 1'b1;
                ctrl.wbSel  = WbLink;
                ctrl.isJump = 1'b1;
                ctrl.op1Pc  = 1'b1;   // target from pc
                ctrl.op2Imm = 1'b1;
            end
            OpJalr:
            begin
                ctrl.rdWe    = 1'b1;
                ctrl.wbSel   = WbLink;
                ctrl.isJump  = 1'b1;
                ctrl.op2Imm  = 1'b1;
                ctrl.illegal = instr.i.funct3 != F3Jalr;
            end
            default:
                ctrl.illegal = 1'b1;   // loads, stores, system, unknown
        endcase
        if (ctrl.illegal)
        begin
            ctrl.rdWe     = 1'b0;
            ctrl.isBranch = 1'b0;
            ctrl.isJump   = 1'b0;
        end
    end

    always_comb
    begin
        case (instr.r.opcode)
            OpImm, OpJalr:
                imm = {{(Xlen-12){instr.i.imm[11]}}, instr.i.imm};
            OpBranch:
                imm = {{(Xlen-12){instr.b.imm12}}, instr.b.imm11, instr.b.imm10to5,
                       instr.b.imm4to1, 1'b0};
            OpLui, OpAuipc:
                imm = {instr.u.imm, 12'b0};
            OpJal:
                imm = {{(Xlen-20){instr.j.imm20}}, instr.j.imm19to12, instr.j.imm11,
                       instr.j.imm10to1, 1'b0};
            default:
                imm = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            decStage.valid <= 1'b0;
        else
        begin
            decStage.valid <= inValid;
            if (inValid)
            begin
                decStage.ctrl   <= ctrl;
                decStage.pc     <= pc;
                decStage.rs1Val <= rs1Val;
                decStage.rs2Val <= rs2Val;
                decStage.imm    <= imm;
                decStage.rdAddr <= instr.r.rd;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/resultSelect.sv
`default_nettype none

module resultSelect
    import corePkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  decStageT decStage,
    input  xlenT     aluResult,
    input  logic     branchTaken,
    input  xlenT     target,
    output logic     outValid,
    output resultT   result
);

    xlenT   pcPlus4;
    resultT nextResult;

    assign pcPlus4 = decStage.pc + xlenT'(4);

    always_comb
    begin
        nextResult.rdWe    = decStage.ctrl.rdWe;
        nextResult.rdAddr  = decStage.rdAddr;
        nextResult.illegal = decStage.ctrl.illegal;
        case (decStage.ctrl.wbSel)
            WbImm:
                nextResult.rdData = decStage.imm;   // lui
            WbLink:
                nextResult.rdData = pcPlus4;
            default:
                nextResult.rdData = aluResult;
        endcase
        nextResult.nextPc = (decStage.ctrl.isJump || branchTaken) ? target : pcPlus4;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            outValid <= 1'b0;
            result   <= '0;
        end
        else
        begin
            outValid <= decStage.valid;
            if (decStage.valid)
                result <= nextResult;   // hold last result between instructions
        end
    end

endmodule

`default_nettype wire

//--- hw/rvExecCore.sv
`default_nettype none

module rvExecCore
    import corePkg::*;
    import rvIsaPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      inValid,
    input  instrWordT instr,
    input  xlenT      pc,
    input  xlenT      rs1Val,
    input  xlenT      rs2Val,
    output logic      outValid,
    output resultT    result
);

    decStageT decStage;
    xlenT     aluResult;
    xlenT     target;
    logic     branchTaken;

    instrDecode decode_i (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .instr    (instr),
        .pc       (pc),
        .rs1Val   (rs1Val),
        .rs2Val   (rs2Val),
        .decStage (decStage)
    );

    // purely combinational between the two register stages
    aluExecute execute_i (
        .decStage    (decStage),
        .aluResult   (aluResult),
        .branchTaken (branchTaken),
        .target      (target)
    );

    resultSelect select_i (
        .clk         (clk),
        .rstN        (rstN),
        .decStage    (decStage),
        .aluResult   (aluResult),
        .branchTaken (branchTaken),
        .target      (target),
        .outValid    (outValid),
        .result      (result)
    );

endmodule

`default_nettype wire

//--- hw/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmtT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmtT;

    // branch offset is scattered over the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFmtT;

    typedef struct packed {
        logic [19:0] imm;   // bits 31:12 of the result
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFmtT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFmtT;

    typedef union packed {
        rFmtT r;
        iFmtT i;
        bFmtT b;
        uFmtT u;
        jFmtT j;
    } instrWordT;

    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpAuipc  = 7'b0010111;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;

    // alu funct3
    localparam logic [2:0] F3AddSub = 3'b000;
    localparam logic [2:0] F3Sll    = 3'b001;
    localparam logic [2:0] F3Slt    = 3'b010;
    localparam logic [2:0] F3Sltu   = 3'b011;
    localparam logic [2:0] F3Xor    = 3'b100;
    localparam logic [2:0] F3SrlSra = 3'b101;
    localparam logic [2:0] F3Or     = 3'b110;
    localparam logic [2:0] F3And    = 3'b111;

    // branch funct3
    localparam logic [2:0] F3Beq  = 3'b000;
    localparam logic [2:0] F3Bne  = 3'b001;
    localparam logic [2:0] F3Blt  = 3'b100;
    localparam logic [2:0] F3Bge  = 3'b101;
    localparam logic [2:0] F3Bltu = 3'b110;
    localparam logic [2:0] F3Bgeu = 3'b111;

    localparam logic [2:0] F3Jalr = 3'b000;

    localparam logic [6:0] Funct7Alt = 7'b0100000;   // sub, sra, srai

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass message in the output
verilator --binary --assert --top-module tbTop -f all.f &&
./obj_dir/VtbTop +verilator+error+limit+100 | tee /dev/stderr | grep -q "Test passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- verif/coreChecker.sv
`default_nettype none

module coreChecker
    import corePkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   expPush,
    input  resultT expResult,
    input  logic   outValid,
    input  resultT result,
    output int     checkedCount,
    output int     errorCount
);

    resultT expQ[$];   // oldest instruction first

    function automatic int compareField(string name, xlenT expVal, xlenT actVal);
        if (expVal !== actVal)
        begin
            $display("mismatch %s: expected %h, got %h", name, expVal, actVal);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge clk)
    begin
        if (rstN && expPush)
            expQ.push_back(expResult);
    end

    // outputs are registered on posedge, so look at them half a cycle later
    always @(negedge clk)
    begin
        resultT expected;
        int     wrong;
        if (!rstN)
        begin
            expQ.delete();
            checkedCount = 0;
            errorCount   = 0;
        end
        else if (outValid)
        begin
            if (expQ.size() == 0)
            begin
                $display("error: the core produced a result with no instruction outstanding");
                errorCount++;
            end
            else
            begin
                expected = expQ.pop_front();
                wrong = 0;
                wrong += compareField("rdWe", xlenT'(expected.rdWe), xlenT'(result.rdWe));
                wrong += compareField("illegal", xlenT'(expected.illegal),
                                      xlenT'(result.illegal));
                wrong += compareField("nextPc", expected.nextPc, result.nextPc);
                if (expected.rdWe)   // rd fields are don't care without a write
                begin
                    wrong += compareField("rdAddr", xlenT'(expected.rdAddr),
                                          xlenT'(result.rdAddr));
                    wrong += compareField("rdData", expected.rdData, result.rdData);
                end
                if (wrong == 0)
                    $display("test %0d ok", checkedCount);
                else
                begin
                    $display("test %0d: %0d fields wrong", checkedCount, wrong);
                    errorCount++;
                end
                checkedCount++;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/rvExecCore_assertions.sv
`default_nettype none

module rvExecCoreAssertions
    import corePkg::*;
(
    input logic   clk,
    input logic   rstN,
    input logic   inValid,
    input logic   outValid,
    input resultT result
);

    int failCount = 0;   // read by the testbench at the end

    // two stage latency with no stalls
    outValidLatency: assert property (@(posedge clk) disable iff (!rstN)
        outValid == $past(inValid, 2))
    else
    begin
        failCount++;
        $error("outValid does not follow inValid by two cycles");
    end

    resetClears: assert property (@(posedge clk) !rstN |=> (result == '0 && !outValid))
    else
    begin
        failCount++;
        $error("result or outValid not cleared by reset");
    end

    noWriteWhenIllegal: assert property (@(posedge clk) disable iff (!rstN)
        !(result.rdWe && result.illegal))
    else
    begin
        failCount++;
        $error("rdWe high on an illegal instruction");
    end

endmodule

`default_nettype wire

//--- verif/rvExecCore_testdata.txt
# instr    pc       rs1Val   rs2Val   rdWe rdData nextPc illegal (all hex)
# rdData is ignored when rdWe is 0
002081b3 00000100 00000005 00000007 1 0000000c 00000104 0 # add
402081b3 00000104 00000005 00000007 1 fffffffe 00000108 0 # sub
0020c1b3 00000108 f0f0f0f0 ff00ff00 1 0ff00ff0 0000010c 0 # xor
0020e1b3 0000010c 12340000 00005678 1 12345678 00000110 0 # or
0020f1b3 00000110 f0f0f0f0 0ff00ff0 1 00f000f0 00000114 0 # and
002091b3 00000114 00000001 00000024 1 00000010 00000118 0 # sll uses low 5 bits
0020d1b3 00000118 80000000 00000004 1 08000000 0000011c 0 # srl
4020d1b3 0000011c 80000000 00000004 1 f8000000 00000120 0 # sra negative
0020a1b3 00000120 ffffffff 00000001 1 00000001 00000124 0 # slt -1 < 1
0020b1b3 00000124 ffffffff 00000001 1 00000000 00000128 0 # sltu
fff08193 00000128 00000010 00000000 1 0000000f 0000012c 0 # addi -1
0ff0c193 0000012c 00000f0f 00000000 1 00000ff0 00000130 0 # xori
8000e193 00000130 00000001 00000000 1 fffff801 00000134 0 # ori -2048
7f00f193 00000134 12345678 00000000 1 00000670 00000138 0 # andi
01f09193 00000138 00000003 00000004 1 80000000 0000013c 0 # slli 31
0080d193 0000013c f0000000 00000000 1 00f00000 00000140 0 # srli 8
4080d193 00000140 f0000000 00000000 1 fff00000 00000144 0 # srai 8
ffb0a193 00000144 fffffff0 00000000 1 00000001 00000148 0 # slti -16 < -5
fff0b193 00000148 7fffffff 00000000 1 00000001 0000014c 0 # sltiu imm ffffffff
123452b7 00000200 00000000 00000000 1 12345000 00000204 0 # lui
fffff297 00002000 00000000 00000000 1 00001000 00002004 0 # auipc
00208863 00000400 0000abcd 0000abcd 0 00000000 00000410 0 # beq taken
00208863 00000400 00000001 00000002 0 00000000 00000404 0 # beq not taken
fe209ce3 00000400 00000001 00000002 0 00000000 000003f8 0 # bne taken backward
00209863 00000400 00000005 00000005 0 00000000 00000404 0 # bne not taken
0020c863 00000400 ffffffff 00000001 0 00000000 00000410 0 # blt taken
0020c863 00000400 00000001 ffffffff 0 00000000 00000404 0 # blt not taken
fe20dce3 00000400 00000001 ffffffff 0 00000000 000003f8 0 # bge taken
0020d863 00000400 80000000 00000000 0 00000000 00000404 0 # bge not taken
0020e863 00000400 00000001 ffffffff 0 00000000 00000410 0 # bltu taken
0020e863 00000400 ffffffff 00000001 0 00000000 00000404 0 # bltu not taken
fe20fce3 00000400 ffffffff 00000001 0 00000000 000003f8 0 # bgeu taken
0020f863 00000400 00000001 00000002 0 00000000 00000404 0 # bgeu not taken
100000ef 00000800 00000000 00000000 1 00000804 00000900 0 # jal +0x100
ffdff0ef 00001000 00000000 00000000 1 00001004 00000ffc 0 # jal -4
007082e7 00003000 00001000 00000000 1 00003004 00001006 0 # jalr bit 0 cleared
fff082e7 00003010 00002000 00000000 1 00003014 00001ffe 0 # jalr -1
0000a183 00000500 00000000 00000000 0 00000000 00000504 1 # lw
0020a023 00000504 00000000 00000000 0 00000000 00000508 1 # sw
0000007f 00000508 00000000 00000000 0 00000000 0000050c 1 # unknown opcode
022081b3 0000050c 00000005 00000007 0 00000000 00000510 1 # funct7 not in RV32I
0020a863 00000510 00000000 00000000 0 00000000 00000514 1 # branch funct3 2

//--- verif/tbTop.sv
`default_nettype none

module tbTop
    import corePkg::*;
    import rvIsaPkg::*;
();

    logic      clk;
    logic      rstN;
    logic      inValid;
    instrWordT instr;
    xlenT      pc;
    xlenT      rs1Val;
    xlenT      rs2Val;
    logic      outValid;
    resultT    result;
    logic      expPush;
    resultT    expResult;
    int        checkedCount;
    int        errorCount;
    int        numTests;
    logic      loaded;

    // test vectors as read from the data file
    logic [31:0] instrList[$];
    logic [31:0] pcList[$];
    logic [31:0] rs1List[$];
    logic [31:0] rs2List[$];
    resultT      expList[$];

    rvExecCore dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .instr    (instr),
        .pc       (pc),
        .rs1Val   (rs1Val),
        .rs2Val   (rs2Val),
        .outValid (outValid),
        .result   (result)
    );

    coreChecker checker_i (
        .clk          (clk),
        .rstN         (rstN),
        .expPush      (expPush),
        .expResult    (expResult),
        .outValid     (outValid),
        .result       (result),
        .checkedCount (checkedCount),
        .errorCount   (errorCount)
    );

    bind rvExecCore rvExecCoreAssertions assertions_i (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .outValid (outValid),
        .result   (result)
    );

    always
    begin
        #2 clk = ~clk;
    end

    task automatic loadTests();
        int          fd;
        int          code;
        logic [8*256-1:0] line;
        logic [31:0] f0, f1, f2, f3, f4, f5, f6, f7;
        resultT      expected;
        fd = $fopen("verif/rvExecCore_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("error: cannot open verif/rvExecCore_testdata.txt");
            return;
        end
        while (!$feof(fd))
        begin
            line = '0;
            code = $fgets(line, fd);
            // comment and blank lines do not yield all eight fields
            if (code > 0 &&
                $sscanf(line, "%h %h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6, f7) == 8)
            begin
                expected.rdWe    = f4[0];
                expected.rdAddr  = f0[11:7];   // rd field of the instruction
                expected.rdData  = f5;
                expected.nextPc  = f6;
                expected.illegal = f7[0];
                instrList.push_back(f0);
                pcList.push_back(f1);
                rs1List.push_back(f2);
                rs2List.push_back(f3);
                expList.push_back(expected);
            end
        end
        $fclose(fd);
    endtask

    task automatic driveTest(input int idx);
        instr     = instrList[idx];
        pc        = pcList[idx];
        rs1Val    = rs1List[idx];
        rs2Val    = rs2List[idx];
        inValid   = 1'b1;
        expPush   = 1'b1;
        expResult = expList[idx];
    endtask

    task automatic driveIdle();
        inValid = 1'b0;
        expPush = 1'b0;
    endtask

    initial
    begin
        integer      seed;
        logic [31:0] rnd;
        int          assertFails;
        clk       = 1'b0;
        rstN      = 1'b0;
        inValid   = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1Val    = '0;
        rs2Val    = '0;
        expPush   = 1'b0;
        expResult = '0;
        loaded    = 1'b0;
        seed      = 32'h89d2;
        loadTests();
        numTests = instrList.size();
        loaded   = 1'b1;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        for (int i = 0; i < numTests; i++)
        begin
            @(negedge clk);
            driveTest(i);
            rnd = $random(seed);
            if (rnd[1:0] == 2'b00)   // occasional bubble
            begin
                @(negedge clk);
                driveIdle();
            end
        end
        @(negedge clk);
        driveIdle();

        wait (checkedCount == numTests);
        repeat (4) @(negedge clk);   // catch stray results
        assertFails = dut_i.assertions_i.failCount;
        $display("summary: %0d tests, %0d checked, %0d errors, %0d assertion failures",
                 numTests, checkedCount, errorCount, assertFails);
        if (numTests > 0 && checkedCount == numTests && errorCount == 0 && assertFails == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // watchdog allows three cycles per test plus reset and pipeline margin
    initial
    begin
        wait (loaded);
        repeat (numTests * 3 + 20) @(posedge clk);
        $display("timeout: only %0d of %0d results arrived", checkedCount, numTests);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
